// File: d_cache_consts.svh
`ifndef D_CACHE_CONSTS_SVH
`define D_CACHE_CONSTS_SVH

// Physical address width
`define PADDR_W     15

// Line geometry
`define LINE_BYTES  16
`define OFFSET_W    4

// Bit 4 of the address picks the bank
`define INDEX_W     3
`define TAG_W       7
`define BANK_LINES  8

// Read result
`define RDATA_W     64

`endif

// File: d_cache_pkg.sv
`default_nettype none

`include "d_cache_consts.svh"

package d_cache_pkg;

   typedef logic [`PADDR_W-1:0]      paddr_t;
   typedef logic [`OFFSET_W-1:0]     offset_t;
   typedef logic [`INDEX_W-1:0]      index_t;
   typedef logic [`TAG_W-1:0]        tag_t;
   typedef logic [`LINE_BYTES*8-1:0] line_t;
   typedef logic [`RDATA_W-1:0]      rdata_t;

   // Codes 0..3 select 1, 2, 4 or 8 bytes
   typedef logic [1:0]               size_t;

   // Read controller
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      LOOKUP,
      MISS_WAIT
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bank_if;
   import d_cache_pkg::*;

   // Request strobe, taken at the rising edge
   logic   req_valid;
   logic   req_write;
   index_t req_index;
   tag_t   req_tag;
   line_t  req_wdata;

   // Registered read response
   logic   rsp_valid;
   logic   rsp_miss;
   line_t  rsp_line;

   modport split (
      output req_valid, req_write, req_index, req_tag, req_wdata
   );

   modport bank (
      input  req_valid, req_write, req_index, req_tag, req_wdata,
      output rsp_valid, rsp_miss, rsp_line
   );

   modport mon (
      input  rsp_valid, rsp_miss, rsp_line
   );

endinterface

`default_nettype wire

// File: access_split.sv
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_consts.svh"

module access_split (
   input  wire logic                op_valid_i,
   input  wire logic                op_write_i,
   input  wire d_cache_pkg::paddr_t op_addr_i,
   input  wire d_cache_pkg::size_t  op_size_i,
   input  wire d_cache_pkg::line_t  op_wdata_i,
   bank_if.split                    even_o,
   bank_if.split                    odd_o
);

   localparam int LINE_W = `PADDR_W - `OFFSET_W;

   logic [`OFFSET_W:0] byte_cnt;
   logic [`OFFSET_W:0] end_pos;
   logic               crosses;
   logic               odd_first;
   logic [LINE_W-1:0]  first_line;
   logic [LINE_W-1:0]  next_line;
   logic [LINE_W-1:0]  even_line;
   logic [LINE_W-1:0]  odd_line;

   always_comb begin
      byte_cnt = '0;
      byte_cnt[op_size_i] = 1'b1;
   end

   // Read runs past the end of its line
   assign end_pos = {1'b0, op_addr_i[`OFFSET_W-1:0]} + byte_cnt;
   assign crosses = ~op_write_i & (end_pos > `LINE_BYTES);

   // Next line wraps at the top of the address space
   assign first_line = op_addr_i[`PADDR_W-1:`OFFSET_W];
   assign next_line  = first_line + 1'b1;
   assign odd_first  = op_addr_i[`OFFSET_W];

   assign even_line = odd_first ? next_line : first_line;
   assign odd_line  = odd_first ? first_line : next_line;

   assign even_o.req_valid = op_valid_i & (~odd_first | crosses);
   assign even_o.req_write = op_write_i;
   assign even_o.req_index = even_line[`INDEX_W:1];
   assign even_o.req_tag   = even_line[`INDEX_W+`TAG_W:`INDEX_W+1];
   assign even_o.req_wdata = op_wdata_i;

   assign odd_o.req_valid = op_valid_i & (odd_first | crosses);
   assign odd_o.req_write = op_write_i;
   assign odd_o.req_index = odd_line[`INDEX_W:1];
   assign odd_o.req_tag   = odd_line[`INDEX_W+`TAG_W:`INDEX_W+1];
   assign odd_o.req_wdata = op_wdata_i;

endmodule

`default_nettype wire

// File: cache_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_consts.svh"

module cache_bank (
   input  wire logic clk,
   input  wire logic rst_n_i,
   bank_if.bank      bank_io
);
   import d_cache_pkg::*;

   logic [`BANK_LINES-1:0] valid_q;
   tag_t                   tag_q  [`BANK_LINES];
   line_t                  data_q [`BANK_LINES];
   logic                   rd_req;
   logic                   wr_req;
   index_t                 idx;

   assign idx    = bank_io.req_index;
   assign rd_req = bank_io.req_valid & ~bank_io.req_write;
   assign wr_req = bank_io.req_valid & bank_io.req_write;

   // Valid bits and response strobe
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q           <= '0;
         bank_io.rsp_valid <= 1'b0;
      end else begin
         bank_io.rsp_valid <= rd_req;
         if (wr_req) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   // A write replaces the whole line
   always_ff @(posedge clk) begin
      if (wr_req) begin
         tag_q[idx]  <= bank_io.req_tag;
         data_q[idx] <= bank_io.req_wdata;
      end
   end

   // Lookup sees the contents from before this edge
   always_ff @(posedge clk) begin
      if (rd_req) begin
         bank_io.rsp_line <= data_q[idx];
         bank_io.rsp_miss <= ~valid_q[idx] | (tag_q[idx] != bank_io.req_tag);
      end
   end

   // Each read gets a response one cycle later with a known miss flag
   rsp_follows_read: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      rd_req |=> bank_io.rsp_valid && !$isunknown(bank_io.rsp_miss)
   );

endmodule

`default_nettype wire

// File: output_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_consts.svh"

module output_align (
   input  wire logic                clk,
   input  wire logic                rst_n_i,
   input  wire d_cache_pkg::paddr_t addr_i,
   input  wire d_cache_pkg::size_t  size_i,
   bank_if.mon                      even_i,
   bank_if.mon                      odd_i,
   output logic                     data_valid_o,
   output d_cache_pkg::rdata_t      data_o
);
   import d_cache_pkg::*;

   offset_t                    offset_q;
   size_t                      size_q;
   logic                       odd_first_q;
   line_t                      first_line;
   line_t                      next_line;
   logic [2*`LINE_BYTES*8-1:0] joined;
   logic [2*`LINE_BYTES*8-1:0] joined_sh;
   rdata_t                     mask;
   logic                       any_rsp;
   logic                       any_miss;

   // Captured alongside the bank lookup
   always_ff @(posedge clk) begin
      offset_q    <= addr_i[`OFFSET_W-1:0];
      size_q      <= size_i;
      odd_first_q <= addr_i[`OFFSET_W];
   end

   assign first_line = odd_first_q ? odd_i.rsp_line : even_i.rsp_line;
   assign next_line  = odd_first_q ? even_i.rsp_line : odd_i.rsp_line;
   assign joined     = {next_line, first_line};
   assign joined_sh  = joined >> {offset_q, 3'b000};

   // Bytes past the size read as zero
   always_comb begin
      mask = '0;
      for (int b = 0; b < `RDATA_W / 8; b++) begin
         if (b < (1 << size_q)) begin
            mask[b*8 +: 8] = 8'hFF;
         end
      end
   end

   assign any_rsp  = even_i.rsp_valid | odd_i.rsp_valid;
   assign any_miss = (even_i.rsp_valid & even_i.rsp_miss) |
                     (odd_i.rsp_valid & odd_i.rsp_miss);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         data_valid_o <= 1'b0;
      end else begin
         data_valid_o <= any_rsp & ~any_miss;
      end
   end

   always_ff @(posedge clk) begin
      if (any_rsp) begin
         data_o <= joined_sh[`RDATA_W-1:0] & mask;
      end
   end

endmodule

`default_nettype wire

// File: access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_consts.svh"

module access_ctrl (
   input  wire logic                clk,
   input  wire logic                rst_n_i,
   input  wire logic                rd_valid_i,
   input  wire d_cache_pkg::paddr_t rd_addr_i,
   input  wire d_cache_pkg::size_t  rd_size_i,
   input  wire logic                wb_valid_i,
   input  wire d_cache_pkg::paddr_t wb_addr_i,
   input  wire d_cache_pkg::line_t  wb_data_i,
   output logic                     op_valid_o,
   output logic                     op_write_o,
   output d_cache_pkg::paddr_t      op_addr_o,
   output d_cache_pkg::size_t       op_size_o,
   output d_cache_pkg::line_t       op_wdata_o,
   output logic                     stall_o,
   output logic                     miss_o,
   output d_cache_pkg::paddr_t      miss_addr_o,
   bank_if.mon                      even_i,
   bank_if.mon                      odd_i
);
   import d_cache_pkg::*;

   localparam int LINE_W = `PADDR_W - `OFFSET_W;

   ctrl_state_t       state_q;
   ctrl_state_t       state_d;
   paddr_t            hold_addr_q;
   size_t             hold_size_q;
   logic              accept;
   logic              rd_issue;
   logic [LINE_W-1:0] first_line;
   logic [LINE_W-1:0] next_line;
   logic [LINE_W-1:0] miss_line;
   logic [LINE_W-1:0] wb_line;
   logic              first_miss;
   logic              next_miss;
   logic              any_miss;

   assign accept   = (state_q == IDLE) & rd_valid_i;
   // Write-backs own the bank port whenever present
   assign rd_issue = ~wb_valid_i & (accept | (state_q == ISSUE));

   assign op_valid_o = wb_valid_i | rd_issue;
   assign op_write_o = wb_valid_i;
   assign op_wdata_o = wb_data_i;
   assign op_size_o  = (state_q == IDLE) ? rd_size_i : hold_size_q;

   always_comb begin
      if (wb_valid_i) begin
         op_addr_o = wb_addr_i;
      end else if (state_q == IDLE) begin
         op_addr_o = rd_addr_i;
      end else begin
         op_addr_o = hold_addr_q;
      end
   end

   assign stall_o = (state_q != IDLE);

   // Which of the held read's lines missed
   assign first_line = hold_addr_q[`PADDR_W-1:`OFFSET_W];
   assign next_line  = first_line + 1'b1;
   assign wb_line    = wb_addr_i[`PADDR_W-1:`OFFSET_W];
   assign first_miss = hold_addr_q[`OFFSET_W] ? (odd_i.rsp_valid & odd_i.rsp_miss)
                                              : (even_i.rsp_valid & even_i.rsp_miss);
   assign next_miss  = hold_addr_q[`OFFSET_W] ? (even_i.rsp_valid & even_i.rsp_miss)
                                              : (odd_i.rsp_valid & odd_i.rsp_miss);
   assign any_miss   = first_miss | next_miss;

   // After a wrap the next line sits at address zero
   assign miss_line = (next_miss & (~first_miss | (next_line == '0))) ? next_line
                                                                      : first_line;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (rd_valid_i) begin
               state_d = wb_valid_i ? ISSUE : LOOKUP;
            end
         end
         ISSUE: begin
            if (!wb_valid_i) begin
               state_d = LOOKUP;
            end
         end
         LOOKUP: begin
            if (!any_miss) begin
               state_d = IDLE;
            end else if (wb_valid_i && (wb_line == miss_line)) begin
               state_d = ISSUE;
            end else begin
               state_d = MISS_WAIT;
            end
         end
         MISS_WAIT: begin
            if (wb_valid_i && (wb_line == miss_addr_o[`PADDR_W-1:`OFFSET_W])) begin
               state_d = ISSUE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         miss_o  <= 1'b0;
      end else begin
         state_q <= state_d;
         miss_o  <= (state_q == LOOKUP) & any_miss;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         hold_addr_q <= rd_addr_i;
         hold_size_q <= rd_size_i;
      end
      if ((state_q == LOOKUP) && any_miss) begin
         miss_addr_o <= {miss_line, {`OFFSET_W{1'b0}}};
      end
   end

   // Only one read in flight
   no_read_in_stall: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      stall_o |-> !rd_valid_i
   );

   miss_single_pulse: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      miss_o |=> !miss_o
   );

endmodule

`default_nettype wire

// File: d_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module d_cache_top (
   input  wire logic                clk,
   input  wire logic                rst_n_i,
   input  wire logic                rd_valid_i,
   input  wire d_cache_pkg::paddr_t rd_addr_i,
   input  wire d_cache_pkg::size_t  rd_size_i,
   input  wire logic                wb_valid_i,
   input  wire d_cache_pkg::paddr_t wb_addr_i,
   input  wire d_cache_pkg::line_t  wb_data_i,
   output logic                     stall_o,
   output logic                     data_valid_o,
   output d_cache_pkg::rdata_t      data_o,
   output logic                     miss_o,
   output d_cache_pkg::paddr_t      miss_addr_o
);
   import d_cache_pkg::*;

   // Current bank operation
   logic   op_valid;
   logic   op_write;
   paddr_t op_addr;
   size_t  op_size;
   line_t  op_wdata;

   bank_if even_if ();
   bank_if odd_if ();

   access_ctrl access_ctrl_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rd_valid_i  (rd_valid_i),
      .rd_addr_i   (rd_addr_i),
      .rd_size_i   (rd_size_i),
      .wb_valid_i  (wb_valid_i),
      .wb_addr_i   (wb_addr_i),
      .wb_data_i   (wb_data_i),
      .op_valid_o  (op_valid),
      .op_write_o  (op_write),
      .op_addr_o   (op_addr),
      .op_size_o   (op_size),
      .op_wdata_o  (op_wdata),
      .stall_o     (stall_o),
      .miss_o      (miss_o),
      .miss_addr_o (miss_addr_o),
      .even_i      (even_if),
      .odd_i       (odd_if)
   );

   access_split access_split_i (
      .op_valid_i (op_valid),
      .op_write_i (op_write),
      .op_addr_i  (op_addr),
      .op_size_i  (op_size),
      .op_wdata_i (op_wdata),
      .even_o     (even_if),
      .odd_o      (odd_if)
   );

   cache_bank bank_e (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bank_io (even_if)
   );

   cache_bank bank_o (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bank_io (odd_if)
   );

   output_align output_align_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .addr_i       (op_addr),
      .size_i       (op_size),
      .even_i       (even_if),
      .odd_i        (odd_if),
      .data_valid_o (data_valid_o),
      .data_o       (data_o)
   );

endmodule

`default_nettype wire

// File: tb_d_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "d_cache_consts.svh"

module tb_d_cache;
   import d_cache_pkg::*;

   localparam int LINE_W     = `PADDR_W - `OFFSET_W;
   localparam int NUM_READS  = 400;
   localparam int MAX_CYCLES = NUM_READS * 20 + 200;

   logic   clk = 1'b0;
   logic   rst_n_i;
   logic   rd_valid_i;
   paddr_t rd_addr_i;
   size_t  rd_size_i;
   logic   wb_valid_i;
   paddr_t wb_addr_i;
   line_t  wb_data_i;
   logic   stall_o;
   logic   data_valid_o;
   rdata_t data_o;
   logic   miss_o;
   paddr_t miss_addr_o;

   integer seed = 44342;
   int     cycle_cnt = 0;
   int     data_errs = 0;
   int     addr_errs = 0;
   int     bit_errs = 0;

   // Backing memory and a copy of each bank's directory
   line_t             mem       [1 << LINE_W];
   logic              dir_valid [2][`BANK_LINES];
   logic [`TAG_W-1:0] dir_tag   [2][`BANK_LINES];
   logic [LINE_W-1:0] last_line;

   d_cache_top d_cache_top_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .rd_valid_i   (rd_valid_i),
      .rd_addr_i    (rd_addr_i),
      .rd_size_i    (rd_size_i),
      .wb_valid_i   (wb_valid_i),
      .wb_addr_i    (wb_addr_i),
      .wb_data_i    (wb_data_i),
      .stall_o      (stall_o),
      .data_valid_o (data_valid_o),
      .data_o       (data_o),
      .miss_o       (miss_o),
      .miss_addr_o  (miss_addr_o)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic check_data(input rdata_t got, input rdata_t exp, input string msg);
      if (got !== exp) begin
         data_errs++;
         $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_addr(input paddr_t got, input paddr_t exp, input string msg);
      if (got !== exp) begin
         addr_errs++;
         $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         bit_errs++;
         $display("ERR %0t: %s got %b expected %b", $time, msg, got, exp);
      end
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic line_t random_line();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   // Bit 0 of the line number picks the bank
   function automatic logic line_cached(input logic [LINE_W-1:0] la);
      return dir_valid[la[0]][la[`INDEX_W:1]] &&
             (dir_tag[la[0]][la[`INDEX_W:1]] == la[LINE_W-1:`INDEX_W+1]);
   endfunction

   function automatic logic read_crosses(input paddr_t addr, input size_t size);
      return ({1'b0, addr[`OFFSET_W-1:0]} + (5'd1 << size)) > `LINE_BYTES;
   endfunction

   function automatic logic read_hits(input paddr_t addr, input size_t size);
      logic [LINE_W-1:0] first;
      first = addr[`PADDR_W-1:`OFFSET_W];
      return line_cached(first) && (!read_crosses(addr, size) || line_cached(first + 1'b1));
   endfunction

   // Lowest-addressed line that is not cached
   function automatic paddr_t missing_line(input paddr_t addr, input size_t size);
      logic [LINE_W-1:0] first;
      logic [LINE_W-1:0] next;
      logic              first_out;
      logic              next_out;
      first     = addr[`PADDR_W-1:`OFFSET_W];
      next      = first + 1'b1;
      first_out = !line_cached(first);
      next_out  = read_crosses(addr, size) && !line_cached(next);
      if (next_out && (!first_out || (next < first))) begin
         return {next, {`OFFSET_W{1'b0}}};
      end
      return {first, {`OFFSET_W{1'b0}}};
   endfunction

   function automatic rdata_t expect_data(input paddr_t addr, input size_t size);
      rdata_t d;
      paddr_t a;
      d = '0;
      for (int k = 0; k < `RDATA_W / 8; k++) begin
         if (k < (1 << size)) begin
            a = addr + k;
            d[k*8 +: 8] = mem[a[`PADDR_W-1:`OFFSET_W]][a[`OFFSET_W-1:0]*8 +: 8];
         end
      end
      return d;
   endfunction

   // Drives one write-back for the coming edge and updates the model
   task automatic drive_writeback(input paddr_t addr, input line_t data);
      logic [LINE_W-1:0] la;
      la = addr[`PADDR_W-1:`OFFSET_W];
      wb_valid_i = 1'b1;
      wb_addr_i  = addr;
      wb_data_i  = data;
      mem[la] = data;
      dir_valid[la[0]][la[`INDEX_W:1]] = 1'b1;
      dir_tag[la[0]][la[`INDEX_W:1]]   = la[LINE_W-1:`INDEX_W+1];
   endtask

   task automatic single_writeback(input paddr_t addr, input line_t data);
      drive_writeback(addr, data);
      @(negedge clk);
      wb_valid_i = 1'b0;
      check_bit(stall_o, 1'b0, "stall while idle");
      check_bit(miss_o, 1'b0, "miss while idle");
      check_bit(data_valid_o, 1'b0, "data_valid while idle");
   endtask

   task automatic run_read(input paddr_t addr, input size_t size);
      int                n;
      int                due;
      int                fill_at;
      int                decoy_at;
      logic              done;
      paddr_t            fill_addr;
      logic [LINE_W-1:0] decoy_la;
      due       = 2;
      fill_at   = -1;
      decoy_at  = -1;
      done      = 1'b0;
      fill_addr = '0;
      last_line = addr[`PADDR_W-1:`OFFSET_W];
      rd_valid_i = 1'b1;
      rd_addr_i  = addr;
      rd_size_i  = size;
      @(negedge clk);
      rd_valid_i = 1'b0;
      n = 1;
      while (!done) begin
         if (n == due) begin
            if (read_hits(addr, size)) begin
               check_bit(data_valid_o, 1'b1, "data_valid on hit");
               check_bit(miss_o, 1'b0, "miss on hit");
               check_bit(stall_o, 1'b0, "stall with result");
               check_data(data_o, expect_data(addr, size), "read data");
               done = 1'b1;
            end else begin
               check_bit(miss_o, 1'b1, "miss pulse");
               check_bit(data_valid_o, 1'b0, "data_valid on miss");
               check_bit(stall_o, 1'b1, "stall on miss");
               fill_addr = missing_line(addr, size);
               check_addr(miss_addr_o, fill_addr, "miss address");
               fill_at  = n + rand_below(4);
               decoy_at = ((fill_at > n) && (rand_below(2) == 0)) ? n : -1;
            end
         end else begin
            check_bit(data_valid_o, 1'b0, "data_valid too early");
            check_bit(miss_o, 1'b0, "unexpected miss");
            check_bit(stall_o, 1'b1, "stall during read");
         end
         if (!done) begin
            wb_valid_i = 1'b0;
            if (n == decoy_at) begin
               // Any other line must leave the read waiting
               decoy_la = fill_addr[`PADDR_W-1:`OFFSET_W] ^ (1 + rand_below(2047));
               drive_writeback({decoy_la, {`OFFSET_W{1'b0}}}, random_line());
            end
            if (n == fill_at) begin
               drive_writeback(fill_addr, mem[fill_addr[`PADDR_W-1:`OFFSET_W]]);
               due = n + 3;
            end
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic random_read();
      paddr_t addr;
      size_t  size;
      int     pick;
      pick = rand_below(8);
      size = size_t'(rand_below(4));
      addr = paddr_t'(rand_below(1 << `PADDR_W));
      if (pick == 1) begin
         addr[`PADDR_W-1:`OFFSET_W] = '1;
      end else if (pick > 1) begin
         // Two tags share every index, so hits and evictions both occur
         addr[`PADDR_W-1:`INDEX_W+`OFFSET_W+1] = (rand_below(2) == 0) ? 7'd0 : 7'd5;
      end
      run_read(addr, size);
   endtask

   task automatic idle_writebacks();
      logic [LINE_W-1:0] la;
      int                pick;
      repeat (rand_below(3)) begin
         pick = rand_below(3);
         la   = last_line;
         if (pick == 1) begin
            la[LINE_W-1:`INDEX_W+1] = la[LINE_W-1:`INDEX_W+1] ^ 7'd5;
         end else if (pick == 2) begin
            la = {(rand_below(2) == 0) ? 7'd0 : 7'd5, 4'(rand_below(16))};
         end
         single_writeback({la, {`OFFSET_W{1'b0}}}, random_line());
      end
   endtask

   initial begin
      rst_n_i    = 1'b0;
      rd_valid_i = 1'b0;
      rd_addr_i  = '0;
      rd_size_i  = '0;
      wb_valid_i = 1'b0;
      wb_addr_i  = '0;
      wb_data_i  = '0;
      last_line  = '0;
      for (int i = 0; i < (1 << LINE_W); i++) begin
         mem[i] = random_line();
      end
      for (int b = 0; b < 2; b++) begin
         for (int i = 0; i < `BANK_LINES; i++) begin
            dir_valid[b][i] = 1'b0;
            dir_tag[b][i]   = '0;
         end
      end
      repeat (3) @(negedge clk);
      rst_n_i = 1'b1;
      @(negedge clk);
      check_bit(stall_o, 1'b0, "stall after reset");
      check_bit(data_valid_o, 1'b0, "data_valid after reset");
      check_bit(miss_o, 1'b0, "miss after reset");

      run_read(15'h0040, 2'd2);
      run_read(15'h0044, 2'd1);
      // Same index and bank, other tag
      single_writeback(15'h0540, random_line());
      run_read(15'h0048, 2'd3);
      single_writeback(15'h0040, random_line());
      run_read(15'h0040, 2'd3);
      run_read(15'h7FFC, 2'd3);
      run_read(15'h001E, 2'd3);
      for (int r = 6; r < NUM_READS; r++) begin
         idle_writebacks();
         random_read();
      end

      $display("errors: data %0d, address %0d, flag %0d", data_errs, addr_errs, bit_errs);
      if ((data_errs + addr_errs + bit_errs) == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      wait (cycle_cnt >= MAX_CYCLES);
      $display("Run stopped after %0d cycles without finishing the reads", cycle_cnt);
      $display("errors: data %0d, address %0d, flag %0d", data_errs, addr_errs, bit_errs);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: d_cache.f
+incdir+.
d_cache_pkg.sv
bank_if.sv
access_split.sv
cache_bank.sv
output_align.sv
access_ctrl.sv
d_cache_top.sv
tb_d_cache.sv
